// ==== all.f ====
logic/rv_core_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/idu2exu.sv
logic/exu_alu.sv
logic/dec_exe_top.sv
verif/dec_exe_assertions.sv
verif/tb_dec_exe.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the decode/execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_dec_exe -f all.f \
    --Mdir obj_dir -o sim_dec_exe \
    && ./obj_dir/sim_dec_exe | tee /dev/stderr | grep -q '^>>> PASS$' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verif/tb_dec_exe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dec_exe;
    import rv_core_pkg::*;

    localparam int TIMEOUT = 50;
    localparam logic [6:0] OPC_OP = 7'h33;
    localparam logic [6:0] OPC_IMM = 7'h13;
    localparam logic [6:0] OPC_LUI = 7'h37;
    localparam logic [6:0] OPC_AUIPC = 7'h17;

    logic i_sys_clk;
    logic i_sys_rst_n;
    logic i_inst_valid;
    logic [31:0] i_inst;
    logic [XLEN-1:0] i_pc;
    logic o_inst_ready;
    logic o_wb_valid;
    logic [XLEN-1:0] o_wb_pc;
    logic [4:0] o_wb_rd;
    logic [XLEN-1:0] o_wb_data;
    logic o_wb_illegal;
    logic i_wb_ready;

    logic [31:0] model [32]; // Architectural register model
    logic [31:0] exp_pc_q[$];
    logic [31:0] exp_rd_q[$];
    logic [31:0] exp_data_q[$];
    logic [31:0] exp_ill_q[$];
    logic [31:0] cur_pc;
    int errors = 0;
    int timeouts = 0;

    dec_exe_top #(.NUM_REGS(32)) DUT (.*);

    initial begin
        i_sys_clk = 1'b0;
        forever #20 i_sys_clk = ~i_sys_clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    // Reference model from the ISA rules, updated in issue order
    task automatic predict(input logic [31:0] inst, input logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [2:0]  f3;
        logic        ill;
        a   = model[inst[19:15]];
        b   = model[inst[24:20]];
        imm = {{20{inst[31]}}, inst[31:20]};
        f3  = inst[14:12];
        res = '0;
        ill = 1'b0;
        case (inst[6:0])
            OPC_OP: begin
                if (inst[31:25] == 7'h20 && f3 == 3'd0) res = a - b;
                else if (inst[31:25] != 7'h00) ill = 1'b1;
                else begin
                    case (f3)
                        3'd0: res = a + b;
                        3'd7: res = a & b;
                        3'd6: res = a | b;
                        3'd4: res = a ^ b;
                        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd1: res = a << b[4:0];
                        3'd5: res = a >> b[4:0];
                        default: ill = 1'b1;
                    endcase
                end
            end
            OPC_IMM: begin
                case (f3)
                    3'd0: res = a + imm;
                    3'd7: res = a & imm;
                    3'd6: res = a | imm;
                    3'd4: res = a ^ imm;
                    3'd2: res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                    default: ill = 1'b1;
                endcase
            end
            OPC_LUI: res = {inst[31:12], 12'h000};
            OPC_AUIPC: res = pc + {inst[31:12], 12'h000};
            default: ill = 1'b1;
        endcase
        if (!ill && inst[11:7] != 5'd0) model[inst[11:7]] = res;
        exp_pc_q.push_back(pc);
        exp_rd_q.push_back({27'd0, inst[11:7]});
        exp_data_q.push_back(res);
        exp_ill_q.push_back({31'd0, ill});
    endtask

    // Result monitor samples mid low phase
    always begin
        @(negedge i_sys_clk);
        #10;
        if (i_sys_rst_n && o_wb_valid && i_wb_ready) begin
            if (exp_pc_q.size() == 0) begin
                timeouts++;
                $display("Unexpected result at t=%0t with no instruction pending", $time);
            end
            else begin
                check("o_wb_pc", o_wb_pc, exp_pc_q.pop_front());
                check("o_wb_rd", {27'd0, o_wb_rd}, exp_rd_q.pop_front());
                check("o_wb_illegal", {31'd0, o_wb_illegal}, exp_ill_q[0]);
                if (exp_ill_q.pop_front() == 0) check("o_wb_data", o_wb_data, exp_data_q[0]);
                void'(exp_data_q.pop_front());
            end
        end
    end

    task automatic issue(input logic [31:0] inst, output int stalls);
        int n;
        n = 0;
        @(negedge i_sys_clk);
        i_inst_valid = 1'b1;
        i_inst       = inst;
        i_pc         = cur_pc;
        #5;
        while (!o_inst_ready && n < TIMEOUT) begin
            @(negedge i_sys_clk);
            #5;
            n++;
        end
        stalls = n;
        if (!o_inst_ready) begin
            timeouts++;
            $display("Timeout: instruction at pc %h was never accepted", cur_pc);
        end
        else predict(inst, cur_pc);
        @(posedge i_sys_clk);
        cur_pc = cur_pc + 4;
    endtask

    task automatic run(input logic [31:0] inst);
        int s;
        issue(inst, s);
    endtask

    task automatic drain();
        int n;
        n = 0;
        @(negedge i_sys_clk);
        i_inst_valid = 1'b0;
        while (exp_pc_q.size() != 0 && n < TIMEOUT) begin
            @(negedge i_sys_clk);
            n++;
        end
        if (exp_pc_q.size() != 0) begin
            timeouts++;
            $display("Timeout: %0d results never came out", exp_pc_q.size());
            exp_pc_q.delete();
            exp_rd_q.delete();
            exp_data_q.delete();
            exp_ill_q.delete();
        end
    endtask

    task automatic after_reset();
        @(negedge i_sys_clk);
        #5;
        check("o_wb_valid", {31'd0, o_wb_valid}, 32'd0);
        check("o_inst_ready", {31'd0, o_inst_ready}, 32'd1);
        run(rtype_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        drain();
    endtask

    task automatic reg_reg_ops();
        logic [31:0] u;
        logic [9:0]  ops [8];
        ops = '{{7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd7}, {7'h00, 3'd6},
                {7'h00, 3'd4}, {7'h00, 3'd2}, {7'h00, 3'd1}, {7'h00, 3'd5}};
        for (int r = 1; r <= 8; r++) begin
            u = $urandom;
            run({u[31:12], r[4:0], OPC_LUI});
            run(itype_word(u[11:0], r[4:0], 3'd0, r[4:0]));
        end
        for (int k = 0; k < 24; k++) begin
            run(rtype_word(ops[k % 8][9:3], 5'($urandom_range(1, 8)),
                           5'($urandom_range(1, 8)), ops[k % 8][2:0], 5'(10 + k % 8)));
        end
        drain();
    endtask

    task automatic imm_ops();
        run(itype_word(12'hffb, 5'd1, 3'd0, 5'd11)); // ADDI -5
        run(itype_word(12'h800, 5'd2, 3'd7, 5'd12));
        run(itype_word(12'hf0f, 5'd3, 3'd6, 5'd13));
        run(itype_word(12'hfff, 5'd4, 3'd4, 5'd14));
        run(itype_word(12'hff0, 5'd5, 3'd2, 5'd15));
        run(itype_word(12'h7ff, 5'd0, 3'd2, 5'd16));
        run({20'habcde, 5'd17, OPC_LUI});
        cur_pc = 32'h1000_0040;
        run({20'h00012, 5'd18, OPC_AUIPC});
        run({20'hfffff, 5'd19, OPC_AUIPC});
        drain();
    endtask

    task automatic dep_chain();
        int s;
        run(itype_word(12'h007, 5'd0, 3'd0, 5'd20));
        for (int k = 0; k < 10; k++) begin
            case (k % 4)
                0: issue(rtype_word(7'h00, 5'd1, 5'd20, 3'd0, 5'd20), s);
                1: issue(itype_word(12'h5a5, 5'd20, 3'd4, 5'd20), s);
                2: issue(rtype_word(7'h00, 5'd20, 5'd20, 3'd1, 5'd20), s);
                default: issue(rtype_word(7'h20, 5'd2, 5'd20, 3'd0, 5'd20), s);
            endcase
            check("stall cycles", s, 0);
        end
        drain();
    endtask

    task automatic back_pressure();
        logic [31:0] snap_data;
        logic [31:0] snap_pc;
        logic [31:0] inst_b;
        int n;
        @(negedge i_sys_clk);
        i_wb_ready = 1'b0;
        run(rtype_word(7'h00, 5'd2, 5'd1, 3'd4, 5'd21));
        inst_b = rtype_word(7'h00, 5'd1, 5'd21, 3'd0, 5'd22); // Reads the held result
        @(negedge i_sys_clk);
        i_inst_valid = 1'b1;
        i_inst       = inst_b;
        i_pc         = cur_pc;
        #5;
        snap_data = o_wb_data;
        snap_pc   = o_wb_pc;
        n = $urandom_range(3, 10);
        for (int k = 0; k < n; k++) begin
            check("o_wb_valid", {31'd0, o_wb_valid}, 32'd1);
            check("o_inst_ready", {31'd0, o_inst_ready}, 32'd0);
            check("o_wb_data", o_wb_data, snap_data);
            check("o_wb_pc", o_wb_pc, snap_pc);
            @(negedge i_sys_clk);
            #5;
        end
        @(negedge i_sys_clk);
        i_wb_ready = 1'b1;
        #5;
        check("o_inst_ready", {31'd0, o_inst_ready}, 32'd1);
        predict(inst_b, cur_pc);
        @(posedge i_sys_clk);
        cur_pc = cur_pc + 4;
        drain();
    endtask

    task automatic illegal_and_x0();
        run({20'h0, 5'd5, 7'h7f}); // Unknown opcode into x5
        run(rtype_word(7'h01, 5'd2, 5'd1, 3'd0, 5'd6)); // Bad funct7
        run(rtype_word(7'h00, 5'd0, 5'd5, 3'd0, 5'd7));
        run(itype_word(12'h07b, 5'd1, 3'd0, 5'd0));
        run(rtype_word(7'h00, 5'd0, 5'd0, 3'd6, 5'd8));
        drain();
    endtask

    initial begin
        void'($urandom(32'h22bdd498));
        i_sys_rst_n  = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_pc         = '0;
        i_wb_ready   = 1'b1;
        cur_pc       = 32'h0000_0100;
        for (int r = 0; r < 32; r++) model[r] = '0;
        repeat (4) @(posedge i_sys_clk);
        @(negedge i_sys_clk);
        i_sys_rst_n = 1'b1;
        after_reset();
        reg_reg_ops();
        imm_ops();
        dep_chain();
        back_pressure();
        illegal_and_x0();
        $display("Errors: %0d value mismatches, %0d other failures", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end
        else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/dec_exe_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_exe_assertions (
    input wire logic        i_sys_clk,
    input wire logic        i_sys_rst_n,
    input wire logic        i_sys_ready,
    input wire logic        o_sys_valid,
    input wire logic [31:0] o_ifu_pc,
    input wire logic [4:0]  o_idu_rd_idx,
    input wire logic [31:0] o_idu_imm_data,
    input wire logic [3:0]  o_idu_ctr_alu_type
);

    a_reset_clears_valid: assert property (@(posedge i_sys_clk)
        !i_sys_rst_n |=> !o_sys_valid)
        else $error("valid set after reset");

    // Held entry must not move while stalled
    a_stall_stable: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
        (o_sys_valid && !i_sys_ready) |=> ($stable(o_ifu_pc) && $stable(o_idu_rd_idx) &&
        $stable(o_idu_imm_data) && $stable(o_idu_ctr_alu_type)))
        else $error("stage outputs changed under back-pressure");

    a_valid_held: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
        (o_sys_valid && !i_sys_ready) |=> o_sys_valid)
        else $error("valid dropped without a transfer");

endmodule

bind idu2exu dec_exe_assertions u_dec_exe_assertions (.*);

`default_nettype wire

// ==== logic/dec_exe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_exe_top #(
    parameter int NUM_REGS = 32
) (
    input  logic                          i_sys_clk,
    input  logic                          i_sys_rst_n,
    input  logic                          i_inst_valid,
    input  logic [31:0]                   i_inst,
    input  logic [rv_core_pkg::XLEN-1:0] i_pc,
    output logic                          o_inst_ready,
    output logic                          o_wb_valid,
    output logic [rv_core_pkg::XLEN-1:0] o_wb_pc,
    output logic [4:0]                    o_wb_rd,
    output logic [rv_core_pkg::XLEN-1:0] o_wb_data,
    output logic                          o_wb_illegal,
    input  logic                          i_wb_ready
);
    import rv_core_pkg::*;

    // Decode stage
    logic [1:0]      dec_inst_type;
    logic [3:0]      dec_alu_type;
    logic [1:0]      dec_alu_rs1;
    logic            dec_alu_rs2;
    logic            dec_reg_wr_en;
    logic [4:0]      dec_rs1_idx;
    logic [4:0]      dec_rs2_idx;
    logic [4:0]      dec_rd_idx;
    logic [XLEN-1:0] dec_imm;
    logic            dec_illegal;
    logic [XLEN-1:0] rf_rs1_data;
    logic [XLEN-1:0] rf_rs2_data;

    // Execute stage
    logic            ex_valid;
    logic [XLEN-1:0] ex_pc;
    logic [1:0]      ex_inst_type;
    logic [3:0]      ex_alu_type;
    logic [1:0]      ex_alu_rs1;
    logic            ex_alu_rs2;
    logic            ex_reg_wr_en;
    logic            ex_illegal;
    logic [4:0]      ex_rd_idx;
    logic [XLEN-1:0] ex_rs1_data;
    logic [XLEN-1:0] ex_rs2_data;
    logic [XLEN-1:0] ex_imm;
    logic            wb_wr_en;
    logic [4:0]      wb_wr_idx;
    logic [XLEN-1:0] wb_wr_data;

    inst_decoder #(.NUM_REGS(NUM_REGS)) u_inst_decoder (
        .i_inst      (i_inst),
        .o_inst_type (dec_inst_type),
        .o_alu_type  (dec_alu_type),
        .o_alu_rs1   (dec_alu_rs1),
        .o_alu_rs2   (dec_alu_rs2),
        .o_reg_wr_en (dec_reg_wr_en),
        .o_rs1_idx   (dec_rs1_idx),
        .o_rs2_idx   (dec_rs2_idx),
        .o_rd_idx    (dec_rd_idx),
        .o_imm       (dec_imm),
        .o_illegal   (dec_illegal)
    );

    reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst_n (i_sys_rst_n),
        .i_rd_idx_a  (dec_rs1_idx),
        .i_rd_idx_b  (dec_rs2_idx),
        .i_wr_en     (wb_wr_en),
        .i_wr_idx    (wb_wr_idx),
        .i_wr_data   (wb_wr_data),
        .o_rd_data_a (rf_rs1_data),
        .o_rd_data_b (rf_rs2_data)
    );

    idu2exu u_idu2exu (
        .i_sys_clk           (i_sys_clk),
        .i_sys_rst_n         (i_sys_rst_n),
        .i_sys_ready         (i_wb_ready),
        .o_sys_valid         (ex_valid),
        .i_idu_valid         (i_inst_valid),
        .o_idu_ready         (o_inst_ready),
        .i_ifu_pc            (i_pc),
        .o_ifu_pc            (ex_pc),
        .i_idu_ctr_inst_type (dec_inst_type),
        .i_idu_ctr_alu_type  (dec_alu_type),
        .i_idu_ctr_alu_rs1   (dec_alu_rs1),
        .i_idu_ctr_alu_rs2   (dec_alu_rs2),
        .i_idu_ctr_reg_wr_en (dec_reg_wr_en),
        .i_idu_illegal       (dec_illegal),
        .o_idu_ctr_inst_type (ex_inst_type),
        .o_idu_ctr_alu_type  (ex_alu_type),
        .o_idu_ctr_alu_rs1   (ex_alu_rs1),
        .o_idu_ctr_alu_rs2   (ex_alu_rs2),
        .o_idu_ctr_reg_wr_en (ex_reg_wr_en),
        .o_idu_illegal       (ex_illegal),
        .i_idu_rd_idx        (dec_rd_idx),
        .o_idu_rd_idx        (ex_rd_idx),
        .i_idu_rs1_data      (rf_rs1_data),
        .i_idu_rs2_data      (rf_rs2_data),
        .i_idu_imm_data      (dec_imm),
        .o_idu_rs1_data      (ex_rs1_data),
        .o_idu_rs2_data      (ex_rs2_data),
        .o_idu_imm_data      (ex_imm)
    );

    exu_alu u_exu_alu (
        .i_sys_valid  (ex_valid),
        .i_wb_ready   (i_wb_ready),
        .i_pc         (ex_pc),
        .i_inst_type  (ex_inst_type),
        .i_alu_type   (ex_alu_type),
        .i_alu_rs1    (ex_alu_rs1),
        .i_alu_rs2    (ex_alu_rs2),
        .i_reg_wr_en  (ex_reg_wr_en),
        .i_illegal    (ex_illegal),
        .i_rd_idx     (ex_rd_idx),
        .i_rs1_data   (ex_rs1_data),
        .i_rs2_data   (ex_rs2_data),
        .i_imm_data   (ex_imm),
        .o_wb_valid   (o_wb_valid),
        .o_wb_pc      (o_wb_pc),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data),
        .o_wb_illegal (o_wb_illegal),
        .o_rf_wr_en   (wb_wr_en),
        .o_rf_wr_idx  (wb_wr_idx),
        .o_rf_wr_data (wb_wr_data)
    );

endmodule

`default_nettype wire

// ==== logic/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
    input  logic                          i_sys_valid,
    input  logic                          i_wb_ready,
    input  logic [rv_core_pkg::XLEN-1:0] i_pc,
    input  logic [1:0]                    i_inst_type,
    input  logic [3:0]                    i_alu_type,
    input  logic [1:0]                    i_alu_rs1,
    input  logic                          i_alu_rs2,
    input  logic                          i_reg_wr_en,
    input  logic                          i_illegal,
    input  logic [4:0]                    i_rd_idx,
    input  logic [rv_core_pkg::XLEN-1:0] i_rs1_data,
    input  logic [rv_core_pkg::XLEN-1:0] i_rs2_data,
    input  logic [rv_core_pkg::XLEN-1:0] i_imm_data,
    output logic                          o_wb_valid,
    output logic [rv_core_pkg::XLEN-1:0] o_wb_pc,
    output logic [4:0]                    o_wb_rd,
    output logic [rv_core_pkg::XLEN-1:0] o_wb_data,
    output logic                          o_wb_illegal,
    output logic                          o_rf_wr_en,
    output logic [4:0]                    o_rf_wr_idx,
    output logic [rv_core_pkg::XLEN-1:0] o_rf_wr_data
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;

    always_comb begin
        case (i_alu_rs1)
            ALU_RS1_REG: op_a = i_rs1_data;
            ALU_RS1_PC:  op_a = i_pc;
            default:     op_a = '0;
        endcase
    end

    assign op_b = (i_alu_rs2 == ALU_RS2_IMM) ? i_imm_data : i_rs2_data;

    always_comb begin
        case (i_alu_type)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SLT:    result = {{(XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    result = op_a << op_b[4:0];
            ALU_SRL:    result = op_a >> op_b[4:0];
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    assign o_wb_valid   = i_sys_valid;
    assign o_wb_pc      = i_pc;
    assign o_wb_rd      = i_rd_idx;
    assign o_wb_data    = result;
    assign o_wb_illegal = i_illegal;

    // Commit on the transfer-out edge only
    assign o_rf_wr_en   = i_sys_valid && i_wb_ready && i_reg_wr_en && !i_illegal &&
                          (i_inst_type != INST_TYPE_X) && (i_rd_idx != 5'd0);
    assign o_rf_wr_idx  = i_rd_idx;
    assign o_rf_wr_data = result;

endmodule

`default_nettype wire

// ==== logic/idu2exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module idu2exu (
    input  logic                          i_sys_clk,
    input  logic                          i_sys_rst_n,
    input  logic                          i_sys_ready,
    output logic                          o_sys_valid,
    input  logic                          i_idu_valid,
    output logic                          o_idu_ready,

    input  logic [rv_core_pkg::XLEN-1:0] i_ifu_pc,
    output logic [rv_core_pkg::XLEN-1:0] o_ifu_pc,

    input  logic [1:0]                    i_idu_ctr_inst_type,
    input  logic [3:0]                    i_idu_ctr_alu_type,
    input  logic [1:0]                    i_idu_ctr_alu_rs1,
    input  logic                          i_idu_ctr_alu_rs2,
    input  logic                          i_idu_ctr_reg_wr_en,
    input  logic                          i_idu_illegal,
    output logic [1:0]                    o_idu_ctr_inst_type,
    output logic [3:0]                    o_idu_ctr_alu_type,
    output logic [1:0]                    o_idu_ctr_alu_rs1,
    output logic                          o_idu_ctr_alu_rs2,
    output logic                          o_idu_ctr_reg_wr_en,
    output logic                          o_idu_illegal,

    input  logic [4:0]                    i_idu_rd_idx,
    output logic [4:0]                    o_idu_rd_idx,

    input  logic [rv_core_pkg::XLEN-1:0] i_idu_rs1_data,
    input  logic [rv_core_pkg::XLEN-1:0] i_idu_rs2_data,
    input  logic [rv_core_pkg::XLEN-1:0] i_idu_imm_data,
    output logic [rv_core_pkg::XLEN-1:0] o_idu_rs1_data,
    output logic [rv_core_pkg::XLEN-1:0] o_idu_rs2_data,
    output logic [rv_core_pkg::XLEN-1:0] o_idu_imm_data
);
    import rv_core_pkg::*;

    logic load;

    // Empty, or the held entry leaves this cycle
    assign o_idu_ready = !o_sys_valid || i_sys_ready;
    assign load        = i_idu_valid && o_idu_ready;

    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_rst_n) begin
            o_sys_valid <= 1'b0;
        end
        else if (o_idu_ready) begin
            o_sys_valid <= i_idu_valid;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_rst_n) begin
            o_idu_ctr_inst_type <= INST_TYPE_X;
            o_idu_ctr_alu_type  <= ALU_X;
            o_idu_ctr_alu_rs1   <= ALU_RS1_X;
            o_idu_ctr_alu_rs2   <= ALU_RS2_REG;
            o_idu_ctr_reg_wr_en <= 1'b0;
            o_idu_illegal       <= 1'b0;
        end
        else if (load) begin
            o_idu_ctr_inst_type <= i_idu_ctr_inst_type;
            o_idu_ctr_alu_type  <= i_idu_ctr_alu_type;
            o_idu_ctr_alu_rs1   <= i_idu_ctr_alu_rs1;
            o_idu_ctr_alu_rs2   <= i_idu_ctr_alu_rs2;
            o_idu_ctr_reg_wr_en <= i_idu_ctr_reg_wr_en;
            o_idu_illegal       <= i_idu_illegal;
        end
    end

    // Payload
    always_ff @(posedge i_sys_clk) begin
        if (load) begin
            o_ifu_pc       <= i_ifu_pc;
            o_idu_rd_idx   <= i_idu_rd_idx;
            o_idu_rs1_data <= i_idu_rs1_data;
            o_idu_rs2_data <= i_idu_rs2_data;
            o_idu_imm_data <= i_idu_imm_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                          i_sys_clk,
    input  logic                          i_sys_rst_n,
    input  logic [4:0]                    i_rd_idx_a,
    input  logic [4:0]                    i_rd_idx_b,
    input  logic                          i_wr_en,
    input  logic [4:0]                    i_wr_idx,
    input  logic [rv_core_pkg::XLEN-1:0] i_wr_data,
    output logic [rv_core_pkg::XLEN-1:0] o_rd_data_a,
    output logic [rv_core_pkg::XLEN-1:0] o_rd_data_b
);
    import rv_core_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS);

    logic [XLEN-1:0] regs [NUM_REGS];

    function automatic logic [XLEN-1:0] read_port(
        input logic [4:0]      idx,
        input logic [XLEN-1:0] stored,
        input logic            wr_hit
    );
        if (idx == 5'd0 || int'(idx) >= NUM_REGS) begin
            return '0;
        end
        else if (wr_hit) begin
            return i_wr_data; // Write-through
        end
        return stored;
    endfunction

    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end
        else if (i_wr_en && i_wr_idx != 5'd0 && int'(i_wr_idx) < NUM_REGS) begin
            regs[i_wr_idx[IDX_W-1:0]] <= i_wr_data;
        end
    end

    assign o_rd_data_a = read_port(i_rd_idx_a, regs[i_rd_idx_a[IDX_W-1:0]],
                                   i_wr_en && (i_wr_idx == i_rd_idx_a));
    assign o_rd_data_b = read_port(i_rd_idx_b, regs[i_rd_idx_b[IDX_W-1:0]],
                                   i_wr_en && (i_wr_idx == i_rd_idx_b));

endmodule

`default_nettype wire

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder #(
    parameter int NUM_REGS = 32
) (
    input  logic [31:0]                   i_inst,
    output logic [1:0]                    o_inst_type,
    output logic [3:0]                    o_alu_type,
    output logic [1:0]                    o_alu_rs1,
    output logic                          o_alu_rs2,
    output logic                          o_reg_wr_en,
    output logic [4:0]                    o_rs1_idx,
    output logic [4:0]                    o_rs2_idx,
    output logic [4:0]                    o_rd_idx,
    output logic [rv_core_pkg::XLEN-1:0] o_imm,
    output logic                          o_illegal
);
    import rv_core_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    inst_word_u w;
    logic       bad_op;
    logic       rs1_used;
    logic       rs2_used;
    logic       wr_used;
    logic       idx_bad;

    assign w = i_inst;

    always_comb begin
        o_inst_type = INST_TYPE_X;
        o_alu_type  = ALU_X;
        o_alu_rs1   = ALU_RS1_X;
        o_alu_rs2   = ALU_RS2_REG;
        o_rs1_idx   = w.r.rs1;
        o_rs2_idx   = w.r.rs2;
        o_rd_idx    = w.r.rd;
        o_imm       = '0;
        rs1_used    = 1'b0;
        rs2_used    = 1'b0;
        wr_used     = 1'b0;
        bad_op      = 1'b0;
        case (w.r.opcode)
            OPC_OP: begin
                o_inst_type = INST_TYPE_R;
                o_alu_rs1   = ALU_RS1_REG;
                rs1_used    = 1'b1;
                rs2_used    = 1'b1;
                wr_used     = 1'b1;
                case ({w.r.funct7, w.r.funct3})
                    {7'h00, 3'b000}: o_alu_type = ALU_ADD;
                    {7'h20, 3'b000}: o_alu_type = ALU_SUB;
                    {7'h00, 3'b111}: o_alu_type = ALU_AND;
                    {7'h00, 3'b110}: o_alu_type = ALU_OR;
                    {7'h00, 3'b100}: o_alu_type = ALU_XOR;
                    {7'h00, 3'b010}: o_alu_type = ALU_SLT;
                    {7'h00, 3'b001}: o_alu_type = ALU_SLL;
                    {7'h00, 3'b101}: o_alu_type = ALU_SRL;
                    default:         bad_op     = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                o_inst_type = INST_TYPE_I;
                o_alu_rs1   = ALU_RS1_REG;
                o_alu_rs2   = ALU_RS2_IMM;
                o_rs1_idx   = w.i.rs1;
                o_rs2_idx   = '0;
                o_imm       = {{(XLEN - 12){w.i.imm12[11]}}, w.i.imm12};
                rs1_used    = 1'b1;
                wr_used     = 1'b1;
                case (w.i.funct3)
                    3'b000:  o_alu_type = ALU_ADD;
                    3'b111:  o_alu_type = ALU_AND;
                    3'b110:  o_alu_type = ALU_OR;
                    3'b100:  o_alu_type = ALU_XOR;
                    3'b010:  o_alu_type = ALU_SLT;
                    default: bad_op     = 1'b1; // Shift immediates not kept
                endcase
            end
            OPC_LUI, OPC_AUIPC: begin
                o_inst_type = INST_TYPE_U;
                o_alu_rs2   = ALU_RS2_IMM;
                o_rs1_idx   = '0;
                o_rs2_idx   = '0;
                o_imm       = {i_inst[31:12], {(XLEN - 20){1'b0}}};
                wr_used     = 1'b1;
                if (w.r.opcode == OPC_LUI) begin
                    o_alu_type = ALU_PASS_B;
                    o_alu_rs1  = ALU_RS1_ZERO;
                end
                else begin
                    o_alu_type = ALU_ADD;
                    o_alu_rs1  = ALU_RS1_PC;
                end
            end
            default: bad_op = 1'b1;
        endcase
    end

    // Indices past the register count (RV32E)
    assign idx_bad = (rs1_used && int'(o_rs1_idx) >= NUM_REGS) ||
                     (rs2_used && int'(o_rs2_idx) >= NUM_REGS) ||
                     (wr_used  && int'(o_rd_idx)  >= NUM_REGS);

    assign o_illegal   = bad_op || idx_bad;
    assign o_reg_wr_en = wr_used && !o_illegal;

endmodule

`default_nettype wire

// ==== logic/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    localparam int XLEN = 32;

    // Instruction format
    localparam logic [1:0] INST_TYPE_R = 2'd0;
    localparam logic [1:0] INST_TYPE_I = 2'd1;
    localparam logic [1:0] INST_TYPE_U = 2'd2;
    localparam logic [1:0] INST_TYPE_X = 2'd3;

    localparam logic [3:0] ALU_ADD    = 4'd0;
    localparam logic [3:0] ALU_SUB    = 4'd1;
    localparam logic [3:0] ALU_AND    = 4'd2;
    localparam logic [3:0] ALU_OR     = 4'd3;
    localparam logic [3:0] ALU_XOR    = 4'd4;
    localparam logic [3:0] ALU_SLT    = 4'd5;
    localparam logic [3:0] ALU_SLL    = 4'd6;
    localparam logic [3:0] ALU_SRL    = 4'd7;
    localparam logic [3:0] ALU_PASS_B = 4'd8;
    localparam logic [3:0] ALU_X      = 4'd15;

    // Operand A source
    localparam logic [1:0] ALU_RS1_REG  = 2'd0;
    localparam logic [1:0] ALU_RS1_PC   = 2'd1;
    localparam logic [1:0] ALU_RS1_ZERO = 2'd2;
    localparam logic [1:0] ALU_RS1_X    = 2'd3;

    localparam logic ALU_RS2_REG = 1'b0;
    localparam logic ALU_RS2_IMM = 1'b1;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // Same word seen as R or I format
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_word_u;

endpackage

`default_nettype wire
